//--- filelist.f
u1e_pkg.sv
u1e_wb_decoder.sv
u1e_misc_regs.sv
u1e_settings_bridge.sv
u1e_time64.sv
u1e_core.sv
tb_u1e_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps
TOP       ?= tb_u1e_core
RTL_TOP   ?= u1e_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_u1e_core.sv
/* self-checking testbench for u1e_core, drives the external wishbone port
   and checks misc registers, empty slots and VITA time loads */

`timescale 1ns/1ps

module tb_u1e_core;

   import u1e_pkg::*;

   localparam int clk_half    = 10;   // 20 ns period
   localparam int ack_limit   = 16;
   localparam int test_trans  = 120;  // bus transfers in all tests, rounded up
   localparam int extra_cyc   = 80;   // pps waits and counter settling
   localparam int watchdog_ns = (test_trans * 40 + extra_cyc) * 2 * clk_half + 2000;

   logic       wb_clk, wb_rst;
   wb_addr_t   wb_adr_i;
   wb_data_t   wb_dat_i, wb_dat_o;
   logic       wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   logic [7:0] dip_sw_i;
   logic [2:0] debug_pb_i, debug_led_o;
   logic       cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i, pps_i;
   logic       cgen_sync_b_o, cgen_ref_sel_o, pps_int_o;
   vita_time_t vita_time_o;

   int          value_errors = 0;
   int          other_errors = 0;
   int          pps_pulses   = 0;
   wb_data_t    shadow_leds  = '0;   // expected register contents
   wb_data_t    shadow_cgen  = 16'd3;
   wb_data_t    shadow_test  = '0;
   logic [31:0] rnd, new_secs;
   wb_data_t    rd;
   vita_time_t  load_val, v0;
   int          waited;

   u1e_core u1e_core_inst (.*);

   initial
   begin
      wb_clk = 1'b0;
      forever #clk_half wb_clk = ~wb_clk;
   end

   //////////////////////////////
   // reference models
   //////////////////////////////

   function automatic wb_data_t misc_expect(input logic [6:0] off);
      case (off)
         reg_leds:      return shadow_leds;
         reg_switches:  return {5'b0, debug_pb_i, dip_sw_i};
         reg_cgen_ctrl: return shadow_cgen;
         reg_cgen_st:   return {13'b0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         reg_test:      return shadow_test;
         default:       return 16'hBEEF;
      endcase
   endfunction

   // add n ticks, carrying whole seconds into the upper word
   function automatic vita_time_t time_advance(input vita_time_t t, input int unsigned n);
      logic [63:0] tk;
      logic [31:0] secs;
      tk   = {32'd0, t[31:0]} + 64'(n);
      secs = t[63:32] + 32'(tk / 64'(ticks_per_sec));
      return {secs, 32'(tk % 64'(ticks_per_sec))};
   endfunction

   //////////////////////////////
   // comparators
   //////////////////////////////

   task automatic compare_wb_data(input string name, input wb_data_t exp, input wb_data_t act);
      if (exp !== act)
      begin
         $display("error %s expected %h actual %h", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic compare_vita_time(input string name, input vita_time_t lo,
                                    input vita_time_t hi, input vita_time_t act);
      if (act < lo || act > hi)
      begin
         $display("error %s expected %h..%h actual %h", name, lo, hi, act);
         value_errors++;
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      if (exp !== act)
      begin
         $display("error %s expected %b actual %b", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic compare_count(input string name, input int exp, input int act);
      if (exp != act)
      begin
         $display("error %s expected %0d actual %0d", name, exp, act);
         value_errors++;
      end
   endtask

   // board outputs must follow the register contents at all times
   always @(negedge wb_clk)
   begin
      if (!wb_rst)
      begin
         compare_bit("led 0", shadow_leds[0], debug_led_o[1]);
         compare_bit("led 1", shadow_leds[1], debug_led_o[0]);
         compare_bit("led 2", shadow_leds[2], debug_led_o[2]);
         compare_bit("cgen sync_b", shadow_cgen[1], cgen_sync_b_o);
         compare_bit("cgen ref_sel", shadow_cgen[0], cgen_ref_sel_o);
         if (pps_int_o)
            pps_pulses++;
      end
   end

   //////////////////////////////
   // bus and pps tasks
   //////////////////////////////

   task automatic bus_cycle(input wb_addr_t adr, input wb_data_t wdat, input logic we,
                            output wb_data_t rdat);
      int n;
      @(posedge wb_clk);
      wb_adr_i <= adr;
      wb_dat_i <= wdat;
      wb_we_i  <= we;
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      n = 0;
      do
      begin
         @(negedge wb_clk);
         n++;
      end
      while (!wb_ack_o && n < ack_limit);
      if (!wb_ack_o)
      begin
         $display("no acknowledge from the DUT at address %h after %0d cycles", adr, n);
         other_errors++;
      end
      rdat = wb_dat_o;
      @(posedge wb_clk);   // transfer completes here
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic wb_write(input wb_addr_t adr, input wb_data_t wdat);
      wb_data_t unused_rd;
      bus_cycle(adr, wdat, 1'b1, unused_rd);
   endtask

   task automatic wb_read(input wb_addr_t adr, output wb_data_t rdat);
      bus_cycle(adr, '0, 1'b0, rdat);
   endtask

   task automatic check_misc(input logic [6:0] off, input string name);
      wb_data_t val;
      wb_read({slot_misc, off}, val);
      compare_wb_data(name, misc_expect(off), val);
   endtask

   // low half then high half, offset bits 6..2 select the register
   task automatic settings_write(input set_addr_t sa, input set_data_t val);
      wb_write({slot_settings, sa[4:0], 2'b00}, val[15:0]);
      wb_write({slot_settings, sa[4:0], 2'b10}, val[31:16]);
   endtask

   task automatic load_time(input vita_time_t v);
      settings_write(set_addr_t'(sr_time64 + time_secs), v[63:32]);
      settings_write(set_addr_t'(sr_time64 + time_ticks), v[31:0]);
      settings_write(set_addr_t'(sr_time64 + time_load_imm), 32'd0);
   endtask

   task automatic pps_pulse(output int n);
      @(posedge wb_clk);
      pps_i <= 1'b1;
      n = 0;
      do
      begin
         @(negedge wb_clk);
         n++;
      end
      while (!pps_int_o && n < 6);
      if (!pps_int_o)
      begin
         $display("pps_int_o did not pulse within 6 cycles of the PPS edge");
         other_errors++;
      end
   endtask

   initial
   begin
      #watchdog_ns;
      $display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
      $display("=== FAIL ===");
      $finish;
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial
   begin
      rnd = $urandom(32'hfdb4);
      wb_rst   = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      dip_sw_i = '0;
      debug_pb_i = '0;
      cgen_st_status_i = 1'b0;
      cgen_st_ld_i     = 1'b0;
      cgen_st_refmon_i = 1'b0;
      pps_i = 1'b0;
      repeat (4) @(posedge wb_clk);
      wb_rst <= 1'b0;

      // reset values
      @(negedge wb_clk);
      compare_bit("reset pps_int", 1'b0, pps_int_o);
      check_misc(reg_test, "reset test reg");
      check_misc(reg_cgen_ctrl, "reset cgen ctrl");
      check_misc(7'h2a, "reset unmapped");

      for (int i = 0; i < 8; i++)
      begin
         rnd = $urandom();
         @(posedge wb_clk);
         dip_sw_i   <= rnd[7:0];
         debug_pb_i <= rnd[10:8];
         cgen_st_status_i <= rnd[11];
         cgen_st_ld_i     <= rnd[12];
         cgen_st_refmon_i <= rnd[13];
         rnd = $urandom();
         wb_write({slot_misc, reg_leds}, rnd[15:0]);
         shadow_leds = rnd[15:0];
         wb_write({slot_misc, reg_cgen_ctrl}, rnd[31:16]);
         shadow_cgen = rnd[31:16];
         rnd = $urandom();
         wb_write({slot_misc, reg_test}, rnd[15:0]);
         shadow_test = rnd[15:0];
         for (int k = 0; k < 6; k++)
            check_misc(7'(2 * k), "misc readback");   // offset 10 is unmapped
      end

      for (int s = 1; s < 16; s++)
      begin
         if (s != 5)
         begin
            rnd = $urandom();
            wb_read({4'(s), rnd[6:0]}, rd);
            compare_wb_data("empty slot read", 16'h0000, rd);
         end
      end

      // immediate loads
      rnd = $urandom();
      new_secs = $urandom();
      load_val = {new_secs, rnd % ticks_per_sec};
      load_time(load_val);
      @(posedge wb_clk);
      @(negedge wb_clk);
      compare_vita_time("immediate load", load_val, time_advance(load_val, 3), vita_time_o);
      load_val = {new_secs + 32'd7, ticks_per_sec - 32'd5};
      load_time(load_val);
      @(posedge wb_clk);
      repeat (9) @(negedge wb_clk);
      compare_vita_time("ticks wrap", time_advance(load_val, 5), time_advance(load_val, 10),
                        vita_time_o);

      // pps aligned load, then a second pps with the arm already used
      new_secs = $urandom();
      settings_write(set_addr_t'(sr_time64 + time_arm_pps), 32'd1);
      settings_write(set_addr_t'(sr_time64 + time_ticks), 32'd0);
      settings_write(set_addr_t'(sr_time64 + time_secs), new_secs);
      pps_pulse(waited);
      compare_vita_time("pps load", {new_secs, 32'd0}, {new_secs, 32'd2}, vita_time_o);
      repeat (3) @(posedge wb_clk);
      pps_i <= 1'b0;
      repeat (6) @(negedge wb_clk);
      compare_count("pps pulses", 1, pps_pulses);
      v0 = vita_time_o;
      pps_pulse(waited);
      compare_vita_time("pps without arm", time_advance(v0, waited), time_advance(v0, waited),
                        vita_time_o);
      repeat (3) @(posedge wb_clk);
      pps_i <= 1'b0;
      repeat (6) @(negedge wb_clk);
      compare_count("pps pulses", 2, pps_pulses);

      $display("tests done: %0d value errors, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- u1e_core.sv
/* core FPGA control plane top: external wishbone master port, slot decoder,
   misc registers, settings bridge and VITA time counter */

`timescale 1ns/1ps

module u1e_core
  (input  logic                wb_clk,
   input  logic                wb_rst,
   // external wishbone master
   input  u1e_pkg::wb_addr_t   wb_adr_i,
   input  u1e_pkg::wb_data_t   wb_dat_i,
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   output u1e_pkg::wb_data_t   wb_dat_o,
   output logic                wb_ack_o,
   // board io
   input  logic [7:0]          dip_sw_i,
   input  logic [2:0]          debug_pb_i,
   input  logic                cgen_st_status_i,
   input  logic                cgen_st_ld_i,
   input  logic                cgen_st_refmon_i,
   input  logic                pps_i,
   output logic [2:0]          debug_led_o,
   output logic                cgen_sync_b_o,
   output logic                cgen_ref_sel_o,
   // timing
   output u1e_pkg::vita_time_t vita_time_o,
   output logic                pps_int_o);

   import u1e_pkg::*;

   logic                misc_stb, settings_stb;
   logic [wb_off_w-1:0] s_adr;
   wb_data_t            s_dat;
   logic                s_we;
   wb_data_t            misc_dat;
   logic                misc_ack, settings_ack;

   set_addr_t           set_addr;
   set_data_t           set_data;
   logic                set_stb;

   ////////////////////////////////
   // intercon
   ////////////////////////////////

   u1e_wb_decoder u1e_wb_decoder_inst
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .m_adr_i(wb_adr_i), .m_dat_i(wb_dat_i), .m_cyc_i(wb_cyc_i),
      .m_stb_i(wb_stb_i), .m_we_i(wb_we_i),
      .m_dat_o(wb_dat_o), .m_ack_o(wb_ack_o),
      .misc_stb_o(misc_stb), .settings_stb_o(settings_stb),
      .s_adr_o(s_adr), .s_dat_o(s_dat), .s_we_o(s_we),
      .misc_dat_i(misc_dat), .misc_ack_i(misc_ack), .settings_ack_i(settings_ack));

   // slot 0
   u1e_misc_regs u1e_misc_regs_inst
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(misc_stb), .we_i(s_we), .adr_i(s_adr), .dat_i(s_dat),
      .dat_o(misc_dat), .ack_o(misc_ack),
      .dip_sw_i(dip_sw_i), .debug_pb_i(debug_pb_i),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .debug_led_o(debug_led_o), .cgen_sync_b_o(cgen_sync_b_o),
      .cgen_ref_sel_o(cgen_ref_sel_o));

   // slot 5
   u1e_settings_bridge u1e_settings_bridge_inst
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(settings_stb), .we_i(s_we), .adr_i(s_adr), .dat_i(s_dat),
      .ack_o(settings_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   ////////////////////////////////
   // vita time
   ////////////////////////////////

   u1e_time64 u1e_time64_inst
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i),
      .vita_time_o(vita_time_o), .pps_int_o(pps_int_o));

endmodule

//--- u1e_time64.sv
/* 64-bit VITA time counter, seconds and ticks, loaded from settings registers
   either immediately or on the next PPS rising edge; pps_int_o marks each PPS */

`timescale 1ns/1ps

module u1e_time64
  (input  logic                wb_clk,
   input  logic                wb_rst,
   input  logic                set_stb_i,
   input  u1e_pkg::set_addr_t  set_addr_i,
   input  u1e_pkg::set_data_t  set_data_i,
   input  logic                pps_i,
   output u1e_pkg::vita_time_t vita_time_o,
   output logic                pps_int_o);

   import u1e_pkg::*;

   logic [31:0] secs_q, ticks_q;
   logic [31:0] pend_secs_q, pend_ticks_q;
   logic        armed_q;
   logic [1:0]  pps_sync_q;   // [1] is the synchronized level
   logic        pps_last_q;
   logic        pps_edge;
   logic        wr_secs, wr_ticks, wr_arm, wr_load;

   ////////////////////////////////
   // settings decode
   ////////////////////////////////

   assign wr_secs  = set_stb_i & (set_addr_i == set_addr_t'(sr_time64 + time_secs));
   assign wr_ticks = set_stb_i & (set_addr_i == set_addr_t'(sr_time64 + time_ticks));
   assign wr_arm   = set_stb_i & (set_addr_i == set_addr_t'(sr_time64 + time_arm_pps));
   assign wr_load  = set_stb_i & (set_addr_i == set_addr_t'(sr_time64 + time_load_imm));

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pend_secs_q  <= '0;
         pend_ticks_q <= '0;
      end
      else
      begin
         if (wr_secs)
            pend_secs_q <= set_data_i;
         if (wr_ticks)
            pend_ticks_q <= set_data_i;
      end
   end

   ////////////////////////////////
   // pps sync and edge detect
   ////////////////////////////////

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync_q <= '0;
         pps_last_q <= 1'b0;
         pps_int_o  <= 1'b0;
      end
      else
      begin
         pps_sync_q <= {pps_sync_q[0], pps_i};
         pps_last_q <= pps_sync_q[1];
         pps_int_o  <= pps_edge;
      end
   end

   assign pps_edge = pps_sync_q[1] & ~pps_last_q;

   ////////////////////////////////
   // counter and loads
   ////////////////////////////////

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         secs_q  <= '0;
         ticks_q <= '0;
         armed_q <= 1'b0;
      end
      else
      begin
         if (wr_arm)
            armed_q <= set_data_i[0];

         if (wr_load)
         begin
            secs_q  <= pend_secs_q;
            ticks_q <= pend_ticks_q;
         end
         else if (pps_edge & armed_q)
         begin
            secs_q  <= pend_secs_q;
            ticks_q <= pend_ticks_q;
            armed_q <= 1'b0;   // one shot
         end
         else if (ticks_q == ticks_per_sec - 32'd1)
         begin
            ticks_q <= '0;
            secs_q  <= secs_q + 32'd1;
         end
         else
            ticks_q <= ticks_q + 32'd1;
      end
   end

   assign vita_time_o = {secs_q, ticks_q};

endmodule

//--- u1e_settings_bridge.sv
/* slot 5 bridge from 16-bit wishbone to the 32-bit settings bus; the low half
   is held until the high-half write, which fires one settings strobe */

`timescale 1ns/1ps

module u1e_settings_bridge
  (input  logic                         wb_clk,
   input  logic                         wb_rst,
   input  logic                         stb_i,
   input  logic                         we_i,
   input  logic [u1e_pkg::wb_off_w-1:0] adr_i,
   input  u1e_pkg::wb_data_t            dat_i,
   output logic                         ack_o,
   // settings bus
   output logic                         set_stb_o,
   output u1e_pkg::set_addr_t           set_addr_o,
   output u1e_pkg::set_data_t           set_data_o);

   import u1e_pkg::*;

   wb_data_t low_half_q;
   logic     wr_low;
   logic     wr_high;

   // offset bit 1 picks the half, bits 6..2 the register
   assign wr_low  = stb_i & we_i & ~adr_i[1];
   assign wr_high = stb_i & we_i &  adr_i[1];

   ////////////////////////////////
   // payload
   ////////////////////////////////

   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
         low_half_q <= dat_i;

      if (wr_high)
      begin
         set_addr_o <= set_addr_t'(adr_i[wb_off_w-1:2]);
         set_data_o <= {dat_i, low_half_q};
      end
   end

   ////////////////////////////////
   // strobe
   ////////////////////////////////

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_high;   // one cycle after the high write
   end

   // reads are harmless, just ack them
   assign ack_o = stb_i;

endmodule

//--- u1e_misc_regs.sv
/* slot 0 register block: LEDs, clock generator control and status, switches,
   buttons and a scratch register; single-cycle combinational ack */

`timescale 1ns/1ps

module u1e_misc_regs
  (input  logic                         wb_clk,
   input  logic                         wb_rst,
   input  logic                         stb_i,
   input  logic                         we_i,
   input  logic [u1e_pkg::wb_off_w-1:0] adr_i,
   input  u1e_pkg::wb_data_t            dat_i,
   output u1e_pkg::wb_data_t            dat_o,
   output logic                         ack_o,
   // board inputs
   input  logic [7:0]                   dip_sw_i,
   input  logic [2:0]                   debug_pb_i,
   input  logic                         cgen_st_status_i,
   input  logic                         cgen_st_ld_i,
   input  logic                         cgen_st_refmon_i,
   // board outputs
   output logic [2:0]                   debug_led_o,
   output logic                         cgen_sync_b_o,
   output logic                         cgen_ref_sel_o);

   import u1e_pkg::*;

   wb_data_t  leds_q;
   wb_data_t  cgen_ctrl_q;
   wb_data_t  test_q;
   misc_reg_e reg_sel;

   assign reg_sel = misc_reg_e'(adr_i);

   ////////////////////////////////
   // register writes
   ////////////////////////////////

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         leds_q      <= '0;
         cgen_ctrl_q <= wb_data_t'(cgen_ctrl_reset);
         test_q      <= '0;
      end
      else if (stb_i & we_i)
      begin
         case (reg_sel)
            reg_leds:      leds_q      <= dat_i;
            reg_cgen_ctrl: cgen_ctrl_q <= dat_i;
            reg_test:      test_q      <= dat_i;
            default:       ;   // read-only or unmapped
         endcase
      end
   end

   // LEDs are wired out of order on the board
   assign debug_led_o    = {leds_q[2], leds_q[0], leds_q[1]};
   assign cgen_sync_b_o  = cgen_ctrl_q[1];
   assign cgen_ref_sel_o = cgen_ctrl_q[0];

   ////////////////////////////////
   // readback
   ////////////////////////////////

   always_comb
   begin
      case (reg_sel)
         reg_leds:      dat_o = leds_q;
         reg_switches:  dat_o = {5'b0, debug_pb_i, dip_sw_i};
         reg_cgen_ctrl: dat_o = cgen_ctrl_q;
         reg_cgen_st:   dat_o = {13'b0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         reg_test:      dat_o = test_q;
         default:       dat_o = misc_default_rd;
      endcase
   end

   assign ack_o = stb_i;   // always ready

endmodule

//--- u1e_wb_decoder.sv
/* single-master wishbone intercon, routes the strobe to slot 0 or slot 5
   by the top address bits and returns read data and ack; empty slots ack with 0 */

`timescale 1ns/1ps

module u1e_wb_decoder
  (input  logic                             wb_clk,
   input  logic                             wb_rst,
   // master side
   input  u1e_pkg::wb_addr_t                m_adr_i,
   input  u1e_pkg::wb_data_t                m_dat_i,
   input  logic                             m_cyc_i,
   input  logic                             m_stb_i,
   input  logic                             m_we_i,
   output u1e_pkg::wb_data_t                m_dat_o,
   output logic                             m_ack_o,
   // slave side, shared address/data/we
   output logic                             misc_stb_o,
   output logic                             settings_stb_o,
   output logic [u1e_pkg::wb_off_w-1:0]     s_adr_o,
   output u1e_pkg::wb_data_t                s_dat_o,
   output logic                             s_we_o,
   input  u1e_pkg::wb_data_t                misc_dat_i,
   input  logic                             misc_ack_i,
   input  logic                             settings_ack_i);

   import u1e_pkg::*;

   wb_slot_e slot;
   logic     bus_req;

   assign bus_req = m_cyc_i & m_stb_i;
   assign slot    = wb_slot_e'(m_adr_i[wb_aw-1 -: wb_decode_w]);

   // strobes
   assign misc_stb_o     = bus_req & (slot == slot_misc);
   assign settings_stb_o = bus_req & (slot == slot_settings);

   assign s_adr_o = m_adr_i[wb_off_w-1:0];   // offset within slot
   assign s_dat_o = m_dat_i;
   assign s_we_o  = m_we_i;

   ////////////////////////////////
   // read data and ack return
   ////////////////////////////////

   always_comb
   begin
      case (slot)
         slot_misc:
         begin
            m_dat_o = misc_dat_i;
            m_ack_o = misc_ack_i;
         end
         slot_settings:
         begin
            m_dat_o = '0;                    // write-only bridge
            m_ack_o = settings_ack_i;
         end
         default:
         begin
            // nothing behind these slots, answer so the master never hangs
            m_dat_o = '0;
            m_ack_o = bus_req;
         end
      endcase
   end

endmodule

//--- u1e_pkg.sv
/* shared widths, slot map, register offsets and timing constants for the core
   control plane; imported by every RTL module and the testbench */

package u1e_pkg;

   ////////////////////////////////
   // wishbone bus
   ////////////////////////////////

   localparam int wb_dw       = 16;                   // data width
   localparam int wb_aw       = 11;                   // address width
   localparam int wb_decode_w = 4;                    // top bits used for slot select
   localparam int wb_off_w    = wb_aw - wb_decode_w;  // offset inside a slot

   typedef logic [wb_dw-1:0] wb_data_t;
   typedef logic [wb_aw-1:0] wb_addr_t;

   // populated slots only, the rest decode as empty
   typedef enum logic [wb_decode_w-1:0] {
      slot_misc     = 4'd0,
      slot_settings = 4'd5
   } wb_slot_e;

   ////////////////////////////////
   // slot 0 misc registers
   ////////////////////////////////

   typedef enum logic [wb_off_w-1:0] {
      reg_leds      = 7'd0,   // rw
      reg_switches  = 7'd2,   // ro
      reg_cgen_ctrl = 7'd4,   // rw
      reg_cgen_st   = 7'd6,   // ro
      reg_test      = 7'd8    // rw scratch
   } misc_reg_e;

   localparam wb_data_t   misc_default_rd = 16'hBEEF;
   localparam logic [1:0] cgen_ctrl_reset = 2'b11;   // sync_b high, ref_sel high

   ////////////////////////////////
   // settings bus
   ////////////////////////////////

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   localparam set_addr_t sr_time64 = 8'd28;   // 4 regs

   typedef enum logic [7:0] {
      time_secs     = 8'd0,
      time_ticks    = 8'd1,
      time_arm_pps  = 8'd2,
      time_load_imm = 8'd3
   } time_reg_e;

   // vita time, seconds in the upper word
   localparam logic [31:0] ticks_per_sec = 32'd64_000_000;

   typedef logic [63:0] vita_time_t;

endpackage
